// ==== pipelined_fpu.f ====
+incdir+test
hw/fpu_pkg.sv
hw/fp_decode.sv
hw/fp_execute.sv
hw/fp_result.sv
hw/pipelined_fpu.sv
test/pipelined_fpu_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the pipelined FPU testbench with Verilator.
# Exits non-zero when the build fails, the simulator fails or no pass line is seen.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f pipelined_fpu.f \
        --top-module pipelined_fpu_tb -Mdir obj_dir -o sim_fpu; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/sim_fpu)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== test/fpu_tests.svh ====
/*
  Directed tests, included inside the testbench module.
  Expected encodings are IEEE single values worked out by hand,
  rounded toward zero with subnormal inputs read as zero.
*/
`ifndef FPU_TESTS_SVH
`define FPU_TESTS_SVH

    // nothing started yet so outputs must sit at their reset values
    task automatic test_reset_state();
        integer errors_before;
        errors_before = error_count;
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            check_value("reset_done", 32'd0, {31'd0, done});
            check_value("reset_result", 32'd0, result);
        end
        report_test("reset_state", errors_before);
    endtask

    task automatic test_exact();
        integer errors_before;
        errors_before = error_count;
        run_op("add_1p5_2p25", fpu_pkg::OP_ADD, 32'h3FC00000, 32'h40100000, 32'h40700000);
        run_op("sub_5_7p5", fpu_pkg::OP_SUB, 32'h40A00000, 32'h40F00000, 32'hC0200000);
        run_op("mul_3_m0p5", fpu_pkg::OP_MUL, 32'h40400000, 32'hBF000000, 32'hBFC00000);
        run_op("sub_x_x", fpu_pkg::OP_SUB, 32'h40700000, 32'h40700000, 32'h00000000);
        run_op("add_mx_x", fpu_pkg::OP_ADD, 32'hC0700000, 32'h40700000, 32'h00000000); // +0 too
        report_test("exact", errors_before);
    endtask

    task automatic test_truncation();
        integer errors_before;
        errors_before = error_count;
        run_op("add_1_2m24", fpu_pkg::OP_ADD, 32'h3F800000, 32'h33800000, 32'h3F800000);
        // 1.5 * (1 + 2^-23) where nearest-even would give ...02
        run_op("mul_trunc", fpu_pkg::OP_MUL, 32'h3FC00000, 32'h3F800001, 32'h3FC00001);
        run_op("mul_trunc_carry", fpu_pkg::OP_MUL, 32'h3FFFFFFF, 32'h3FFFFFFF, 32'h407FFFFE);
        run_op("sub_1_2m30", fpu_pkg::OP_SUB, 32'h3F800000, 32'h30800000, 32'h3F7FFFFF);
        report_test("truncation", errors_before);
    endtask

    task automatic test_range();
        integer errors_before;
        errors_before = error_count;
        run_op("mul_max_2", fpu_pkg::OP_MUL, 32'h7F7FFFFF, 32'h40000000, 32'h7F800000);
        run_op("mul_mmax_2", fpu_pkg::OP_MUL, 32'hFF7FFFFF, 32'h40000000, 32'hFF800000);
        run_op("mul_mmin_half", fpu_pkg::OP_MUL, 32'h80800000, 32'h3F000000, 32'h80000000);
        run_op("add_sub_a", fpu_pkg::OP_ADD, 32'h00000001, 32'h3F800000, 32'h3F800000);
        run_op("add_sub_b", fpu_pkg::OP_ADD, 32'h3F800000, 32'h007FFFFF, 32'h3F800000);
        report_test("range", errors_before);
    endtask

    task automatic test_special();
        integer errors_before;
        errors_before = error_count;
        run_op("nan_a", fpu_pkg::OP_ADD, 32'hFF812345, 32'h3F800000, 32'hFFC12345); // quieted
        run_op("nan_b", fpu_pkg::OP_MUL, 32'hC0000000, 32'h7FA00001, 32'h7FE00001); // sign of b
        run_op("nan_both", fpu_pkg::OP_SUB, 32'h7FC00003, 32'hFFC00005, 32'h7FC00003);
        run_op("inf_sub_inf", fpu_pkg::OP_SUB, 32'h7F800000, 32'h7F800000, 32'hFFC00000);
        run_op("zero_mul_inf", fpu_pkg::OP_MUL, 32'h00000000, 32'hFF800000, 32'hFFC00000);
        run_op("inf_add_inf", fpu_pkg::OP_ADD, 32'h7F800000, 32'h7F800000, 32'h7F800000);
        run_op("minf_add_1", fpu_pkg::OP_ADD, 32'hFF800000, 32'h3F800000, 32'hFF800000);
        run_op("one_sub_inf", fpu_pkg::OP_SUB, 32'h3F800000, 32'h7F800000, 32'hFF800000);
        run_op("inf_mul_m2", fpu_pkg::OP_MUL, 32'h7F800000, 32'hC0000000, 32'hFF800000);
        run_op("mz_add_mz", fpu_pkg::OP_ADD, 32'h80000000, 32'h80000000, 32'h80000000);
        run_op("z_sub_z", fpu_pkg::OP_SUB, 32'h00000000, 32'h00000000, 32'h00000000);
        run_op("mz_sub_z", fpu_pkg::OP_SUB, 32'h80000000, 32'h00000000, 32'h80000000);
        run_op("z_sub_2p5", fpu_pkg::OP_SUB, 32'h00000000, 32'h40200000, 32'hC0200000);
        run_op("2p5_add_mz", fpu_pkg::OP_ADD, 32'h40200000, 32'h80000000, 32'h40200000);
        run_op("mz_mul_3", fpu_pkg::OP_MUL, 32'h80000000, 32'h40400000, 32'h80000000);
        run_op("unused_op", fpu_pkg::fpu_op_t'(2'd3), 32'h3F800000, 32'h3F800000, 32'h0);
        report_test("special", errors_before);
    endtask

    // six back to back starts with magnitudes 2.25 and 1.5 and random signs
    task automatic test_throughput();
        integer             errors_before;
        fpu_pkg::fpu_op_t   ops [6];
        logic [31:0]        expected_q [$];
        integer             due_q [$];     // cycle in which each done is due
        logic [31:0]        rnd;
        logic               sa, sb, sb_eff, a_big;
        logic [31:0]        expected;
        integer             pulses;
        errors_before = error_count;
        ops    = '{fpu_pkg::OP_ADD, fpu_pkg::OP_SUB, fpu_pkg::OP_MUL,
                   fpu_pkg::OP_SUB, fpu_pkg::OP_ADD, fpu_pkg::OP_MUL};
        pulses = 0;
        for (int c = 0; c < 6 + DONE_TIMEOUT; c++) begin
            @(posedge clk);
            if (done) begin
                pulses = pulses + 1;
                if (due_q.size() == 0) begin
                    error_count = error_count + 1;
                    $display("throughput: done pulse with no operation pending");
                end else begin
                    if (due_q[0] != c) begin
                        error_count = error_count + 1;
                        $display("throughput: done came in cycle %0d instead of %0d",
                                 c, due_q[0]);
                    end
                    check_value("throughput", expected_q.pop_front(), result);
                    void'(due_q.pop_front());
                end
            end
            if (c < 6) begin
                rnd    = $random(seed);
                sa     = rnd[0];
                sb     = rnd[1];
                a_big  = (c % 2 == 0);      // alternate which side is larger
                sb_eff = sb ^ (ops[c] == fpu_pkg::OP_SUB);
                if (ops[c] == fpu_pkg::OP_MUL)
                    expected = {sa ^ sb, 31'h40580000};             // 3.375
                else if (sa == sb_eff)
                    expected = {sa, 31'h40700000};                  // 3.75
                else
                    expected = {a_big ? sa : sb_eff, 31'h3F400000}; // 0.75
                start <= 1'b1;
                op    <= ops[c];
                a     <= {sa, a_big ? 31'h40100000 : 31'h3FC00000};
                b     <= {sb, a_big ? 31'h3FC00000 : 31'h40100000};
                expected_q.push_back(expected);
                due_q.push_back(c + 4);     // sampled at c+1 and done seen three edges later
            end else begin
                start <= 1'b0;
            end
        end
        if (pulses != 6) begin
            error_count = error_count + 1;
            $display("throughput: saw %0d done pulses where 6 were expected", pulses);
        end
        report_test("throughput", errors_before);
    endtask

`endif

// ==== test/pipelined_fpu_tb.sv ====
/*
  Testbench for the three-stage FPU.
  Inputs change on the rising edge via non-blocking assignments, outputs are
  read at the rising edge, before the DUT registers update.
  Every wait on done gives up after DONE_TIMEOUT cycles.
*/
`timescale 1ns/1ps
`default_nettype none

module pipelined_fpu_tb;

    localparam int DONE_TIMEOUT = 20;   // cycles

    logic               clk;
    logic               reset;
    logic               start;
    fpu_pkg::fpu_op_t   op;
    logic [31:0]        a;
    logic [31:0]        b;
    logic               done;
    logic [31:0]        result;

    integer check_count;
    integer error_count;
    integer seed;                       // for $random in the throughput test

    pipelined_fpu DUT (
        .clk    (clk),
        .reset  (reset),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .done   (done),
        .result (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;          // 10 ns period
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // one-cycle start strobe with operands
    task automatic issue_op(input fpu_pkg::fpu_op_t op_in, input logic [31:0] a_in,
                            input logic [31:0] b_in);
        @(posedge clk);
        start <= 1'b1;
        op    <= op_in;
        a     <= a_in;
        b     <= b_in;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_done(input string name, output logic seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(posedge clk);
            cycles = cycles + 1;
            if (done)
                seen = 1'b1;
        end
        if (!seen) begin
            error_count = error_count + 1;
            $display("%s: no done pulse within %0d cycles", name, DONE_TIMEOUT);
        end
    endtask

    task automatic run_op(input string name, input fpu_pkg::fpu_op_t op_in,
                          input logic [31:0] a_in, input logic [31:0] b_in,
                          input logic [31:0] expected);
        logic seen;
        issue_op(op_in, a_in, b_in);
        wait_done(name, seen);
        if (seen)
            check_value(name, expected, result);    // result is held while done is high
    endtask

    task automatic report_test(input string name, input integer errors_before);
        $display("test %s finished with %0d errors", name, error_count - errors_before);
    endtask

    `include "fpu_tests.svh"

    initial begin
        reset       = 1'b1;
        start       = 1'b0;
        op          = fpu_pkg::OP_ADD;
        a           = '0;
        b           = '0;
        check_count = 0;
        error_count = 0;
        seed        = 16011;
        repeat (3) @(posedge clk);      // reset seen on three edges
        reset <= 1'b0;

        test_reset_state();
        test_exact();
        test_truncation();
        test_range();
        test_special();
        test_throughput();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/pipelined_fpu.sv ====
/*
  Three-stage single-precision add, subtract and multiply unit.
  start is a one-cycle strobe; done follows three cycles later.
  No stall or back-pressure, up to three operations in flight.
  Rounding is toward zero only and no exception flags are reported.
*/
`timescale 1ns/1ps
`default_nettype none

module pipelined_fpu (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      start,
    input  wire fpu_pkg::fpu_op_t          op,
    input  wire logic [31:0]               a,
    input  wire logic [31:0]               b,
    output logic                           done,
    output logic [31:0]                    result
);

    // stage 1 to stage 2
    logic                     dec_valid;
    fpu_pkg::fpu_op_t         dec_op;
    logic                     dec_special;
    logic [31:0]              dec_special_value;
    logic                     dec_sign;
    logic                     dec_subtract;
    fpu_pkg::exponent_t       dec_exponent;
    logic [23:0]              dec_frac_a;
    logic [47:0]              dec_frac_b;

    // stage 2 to stage 3
    logic                     exe_valid;
    logic                     exe_special;
    logic [31:0]              exe_special_value;
    logic                     exe_sign;
    fpu_pkg::exponent_t       exe_exponent;
    logic [23:0]              exe_fraction;

    fp_decode u_decode (
        .clk, .reset, .start, .op, .a, .b,
        .dec_valid, .dec_op, .dec_special, .dec_special_value,
        .dec_sign, .dec_subtract, .dec_exponent, .dec_frac_a, .dec_frac_b
    );

    fp_execute u_execute (
        .clk, .reset,
        .dec_valid, .dec_op, .dec_special, .dec_special_value,
        .dec_sign, .dec_subtract, .dec_exponent, .dec_frac_a, .dec_frac_b,
        .exe_valid, .exe_special, .exe_special_value,
        .exe_sign, .exe_exponent, .exe_fraction
    );

    fp_result u_result (
        .clk, .reset,
        .exe_valid, .exe_special, .exe_special_value,
        .exe_sign, .exe_exponent, .exe_fraction,
        .done, .result
    );

endmodule

`default_nettype wire

// ==== hw/fp_result.sv ====
/*
  Stage 3: range check, final select and packing.
  A zero fraction gives +0, so exact cancellation never returns -0.
  Overflow saturates to signed infinity, underflow flushes to signed zero.
  result is cleared by reset and then only changes when done is raised.
*/
`timescale 1ns/1ps
`default_nettype none

module fp_result (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      exe_valid,
    input  wire logic                      exe_special,
    input  wire logic [31:0]               exe_special_value,
    input  wire logic                      exe_sign,
    input  wire fpu_pkg::exponent_t        exe_exponent,
    input  wire logic [23:0]               exe_fraction,
    output logic                           done,
    output logic [31:0]                    result
);

    logic [31:0] packed_value;
    logic        is_zero;
    logic        is_overflow;
    logic        is_underflow;

    always_comb begin
        is_zero      = (exe_fraction == '0);
        is_overflow  = exe_exponent >= fpu_pkg::exponent_t'(fpu_pkg::EXP_MAX);
        is_underflow = exe_exponent <= 10'sd0;

        if (exe_special)
            packed_value = exe_special_value;                       // decided in stage 1
        else if (is_zero)
            packed_value = '0;
        else if (is_overflow)
            packed_value = {exe_sign, fpu_pkg::EXP_MAX, 23'd0};     // signed infinity
        else if (is_underflow)
            packed_value = {exe_sign, 31'd0};                       // signed zero
        else
            packed_value = {exe_sign, exe_exponent[7:0], exe_fraction[22:0]};  // hidden bit dropped
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            done   <= 1'b0;
            result <= '0;
        end else begin
            done <= exe_valid;
            if (exe_valid)
                result <= packed_value;     // held between operations
        end
    end

endmodule

`default_nettype wire

// ==== hw/fp_execute.sv ====
/*
  Stage 2: fraction add, subtract or multiply, then normalize.
  The working fraction is 49 bits, two integer bits and 47 fraction bits.
  Bits below the top 24 of the normalized fraction are dropped, which
  gives round toward zero. Latency is one cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module fp_execute (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      dec_valid,
    input  wire fpu_pkg::fpu_op_t          dec_op,
    input  wire logic                      dec_special,
    input  wire logic [31:0]               dec_special_value,
    input  wire logic                      dec_sign,
    input  wire logic                      dec_subtract,
    input  wire fpu_pkg::exponent_t        dec_exponent,
    input  wire logic [23:0]               dec_frac_a,
    input  wire logic [47:0]               dec_frac_b,
    output logic                           exe_valid,
    output logic                           exe_special,
    output logic [31:0]                    exe_special_value,
    output logic                           exe_sign,
    output fpu_pkg::exponent_t             exe_exponent,
    output logic [23:0]                    exe_fraction
);

    logic [48:0]               ext_a;           // xx.47 aligned copy of a
    logic [48:0]               ext_b;
    logic [47:0]               product;         // 24x24, xx.46
    logic [48:0]               raw;             // unnormalized result
    logic [5:0]                lzc;
    logic [48:0]               norm;
    fpu_pkg::exponent_t        norm_exp;

    // leading zeros over bits 47:0, 48 when all clear
    function automatic logic [5:0] count_leading_zeros(input logic [47:0] value);
        logic [5:0] count;
        logic       found;
        count = 6'd48;
        found = 1'b0;
        for (int i = 47; i >= 0; i--) begin
            if (value[i] && !found) begin
                count = 6'(47 - i);
                found = 1'b1;
            end
        end
        return count;
    endfunction

    always_comb begin
        ext_a   = {1'b0, dec_frac_a, 24'd0};
        ext_b   = {1'b0, dec_frac_b};
        product = dec_frac_a * dec_frac_b[47:24];

        case (dec_op)
            fpu_pkg::OP_ADD, fpu_pkg::OP_SUB:
                raw = dec_subtract ? (ext_a - ext_b) : (ext_a + ext_b);  // a is never smaller
            fpu_pkg::OP_MUL:
                raw = {product, 1'b0};          // line up binary point with the adder
            default:
                raw = '0;
        endcase

        lzc = count_leading_zeros(raw[47:0]);

        if (raw[48]) begin
            // carry out of the integer bit
            norm     = raw >> 1;
            norm_exp = dec_exponent + 10'sd1;
        end else begin
            // zero shift when already normalized, full shift after cancellation
            norm     = raw << lzc;
            norm_exp = dec_exponent - fpu_pkg::exponent_t'({4'd0, lzc});
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            exe_valid <= 1'b0;
        else
            exe_valid <= dec_valid;
    end

    always_ff @(posedge clk) begin
        exe_special       <= dec_special;
        exe_special_value <= dec_special_value;
        exe_sign          <= dec_sign;
        exe_exponent      <= norm_exp;
        exe_fraction      <= norm[47:24];   // truncation
    end

endmodule

`default_nettype wire

// ==== hw/fp_decode.sv ====
/*
  Stage 1: unpack, classify, resolve special cases, sort and align.
  Subnormal inputs are flushed to zero by the classifier.
  Special-case results are fully decided here and carried down the pipe.
  Latency is one cycle; only dec_valid is cleared by reset.
*/
`timescale 1ns/1ps
`default_nettype none

module fp_decode (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic                      start,
    input  wire fpu_pkg::fpu_op_t          op,
    input  wire logic [31:0]               a,
    input  wire logic [31:0]               b,
    output logic                           dec_valid,
    output fpu_pkg::fpu_op_t               dec_op,
    output logic                           dec_special,
    output logic [31:0]                    dec_special_value,
    output logic                           dec_sign,
    output logic                           dec_subtract,
    output fpu_pkg::exponent_t             dec_exponent,
    output logic [23:0]                    dec_frac_a,
    output logic [47:0]                    dec_frac_b
);

    logic                        sign_a, sign_b, sign_b_eff;
    logic [7:0]                  exp_a, exp_b;
    logic [23:0]                 man_a, man_b;          // 1.23 with hidden bit
    fpu_pkg::operand_class_t     class_a, class_b;
    logic                        swap;                  // b has the larger magnitude
    logic [7:0]                  big_exp, small_exp, exp_diff;
    logic [23:0]                 big_man, small_man;
    logic [47:0]                 aligned;               // small fraction after right shift
    logic                        special;
    logic [31:0]                 special_value;
    logic                        sign, subtract;
    fpu_pkg::exponent_t          exponent;
    logic [23:0]                 frac_a;
    logic [47:0]                 frac_b;

    function automatic fpu_pkg::operand_class_t classify(input logic [31:0] value);
        logic [7:0] exp_field;
        exp_field = value[fpu_pkg::FRAC_BITS +: fpu_pkg::EXP_BITS];
        if (exp_field == 8'd0)
            return fpu_pkg::CLASS_ZERO;                 // subnormals land here too
        else if (exp_field == fpu_pkg::EXP_MAX)
            return (value[fpu_pkg::FRAC_BITS-1:0] == '0) ? fpu_pkg::CLASS_INFINITE
                                                         : fpu_pkg::CLASS_NAN;
        else
            return fpu_pkg::CLASS_NORMAL;
    endfunction

    always_comb begin
        sign_a  = a[31];
        sign_b  = b[31];
        exp_a   = a[fpu_pkg::FRAC_BITS +: fpu_pkg::EXP_BITS];
        exp_b   = b[fpu_pkg::FRAC_BITS +: fpu_pkg::EXP_BITS];
        man_a   = {1'b1, a[fpu_pkg::FRAC_BITS-1:0]};   // hidden one, zeros never reach the datapath
        man_b   = {1'b1, b[fpu_pkg::FRAC_BITS-1:0]};
        class_a = classify(a);
        class_b = classify(b);

        sign_b_eff = sign_b ^ (op == fpu_pkg::OP_SUB);  // subtract is add of negated b
        swap       = a[30:0] < b[30:0];                 // magnitude compare on packed bits

        big_exp   = swap ? exp_b : exp_a;
        small_exp = swap ? exp_a : exp_b;
        big_man   = swap ? man_b : man_a;
        small_man = swap ? man_a : man_b;
        exp_diff  = big_exp - small_exp;
        aligned   = (exp_diff >= 8'd48) ? '0 : ({small_man, 24'd0} >> exp_diff);
    end

    // datapath operands for stage 2
    always_comb begin
        case (op)
            fpu_pkg::OP_ADD, fpu_pkg::OP_SUB: begin
                sign     = swap ? sign_b_eff : sign_a;  // larger operand wins the sign
                subtract = sign_a ^ sign_b_eff;
                exponent = fpu_pkg::exponent_t'(big_exp);
                frac_a   = big_man;
                frac_b   = aligned;
            end
            fpu_pkg::OP_MUL: begin
                sign     = sign_a ^ sign_b;
                subtract = 1'b0;
                exponent = fpu_pkg::exponent_t'(exp_a) + fpu_pkg::exponent_t'(exp_b)
                           - fpu_pkg::exponent_t'(fpu_pkg::EXP_BIAS);
                frac_a   = man_a;
                frac_b   = {man_b, 24'd0};              // multiplier sits in the upper half
            end
            default: begin
                sign     = 1'b0;
                subtract = 1'b0;
                exponent = '0;
                frac_a   = '0;
                frac_b   = '0;
            end
        endcase
    end

    // special-case table, +0 unless something below overrides
    always_comb begin
        special       = 1'b1;
        special_value = '0;
        if (op inside {fpu_pkg::OP_ADD, fpu_pkg::OP_SUB, fpu_pkg::OP_MUL}) begin
            if (class_a == fpu_pkg::CLASS_NAN || class_b == fpu_pkg::CLASS_NAN) begin
                // quiet the NaN, a's payload has priority
                special_value = (class_a == fpu_pkg::CLASS_NAN)
                              ? {sign_a, fpu_pkg::EXP_MAX, 1'b1, a[21:0]}
                              : {sign_b, fpu_pkg::EXP_MAX, 1'b1, b[21:0]};
            end else if (op == fpu_pkg::OP_MUL) begin
                if ((class_a == fpu_pkg::CLASS_ZERO && class_b == fpu_pkg::CLASS_INFINITE) ||
                    (class_a == fpu_pkg::CLASS_INFINITE && class_b == fpu_pkg::CLASS_ZERO))
                    special_value = fpu_pkg::DEFAULT_NAN;   // 0 * inf is invalid
                else if (class_a == fpu_pkg::CLASS_INFINITE || class_b == fpu_pkg::CLASS_INFINITE)
                    special_value = {sign_a ^ sign_b, fpu_pkg::EXP_MAX, 23'd0};
                else if (class_a == fpu_pkg::CLASS_ZERO || class_b == fpu_pkg::CLASS_ZERO)
                    special_value = {sign_a ^ sign_b, 31'd0};
                else
                    special = 1'b0;
            end else begin
                if (class_a == fpu_pkg::CLASS_INFINITE && class_b == fpu_pkg::CLASS_INFINITE)
                    special_value = (sign_a ^ sign_b_eff) ? fpu_pkg::DEFAULT_NAN
                                                          : {sign_a, fpu_pkg::EXP_MAX, 23'd0};
                else if (class_a == fpu_pkg::CLASS_INFINITE)
                    special_value = {sign_a, fpu_pkg::EXP_MAX, 23'd0};
                else if (class_b == fpu_pkg::CLASS_INFINITE)
                    special_value = {sign_b_eff, fpu_pkg::EXP_MAX, 23'd0};
                else if (class_a == fpu_pkg::CLASS_ZERO && class_b == fpu_pkg::CLASS_ZERO)
                    special_value = {sign_a & sign_b_eff, 31'd0};   // -0 only if both are -0
                else if (class_a == fpu_pkg::CLASS_ZERO)
                    special_value = {sign_b_eff, b[30:0]};
                else if (class_b == fpu_pkg::CLASS_ZERO)
                    special_value = a;
                else
                    special = 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            dec_valid <= 1'b0;
        else
            dec_valid <= start;
    end

    always_ff @(posedge clk) begin
        dec_op            <= op;
        dec_special       <= special;
        dec_special_value <= special_value;
        dec_sign          <= sign;
        dec_subtract      <= subtract;
        dec_exponent      <= exponent;
        dec_frac_a        <= frac_a;
        dec_frac_b        <= frac_b;
    end

endmodule

`default_nettype wire

// ==== hw/fpu_pkg.sv ====
/*
  Shared definitions for the pipelined single-precision FPU.
  Widths are fixed by the IEEE-754 single format and are not meant to be changed.
  Subnormal operands are classified as zero; there is no subnormal result.
  Opcode value 3 is unused and yields +0.
*/
`default_nettype none

package fpu_pkg;

    // stored field widths of an IEEE single
    localparam int EXP_BITS  = 8;
    localparam int FRAC_BITS = 23;
    localparam int EXP_BIAS  = 127;

    // all ones exponent, shared by infinity and NaN
    localparam logic [EXP_BITS-1:0] EXP_MAX = 8'd255;

    // negative quiet NaN, returned for every invalid operation
    localparam logic [31:0] DEFAULT_NAN = {1'b1, EXP_MAX, 1'b1, {(FRAC_BITS-1){1'b0}}};

    // operation select, value 3 left unused
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,
        OP_SUB = 2'd1,
        OP_MUL = 2'd2
    } fpu_op_t;

    // operand classification after unpacking
    typedef enum logic [1:0] {
        CLASS_ZERO     = 2'd0,  // zero or subnormal
        CLASS_NORMAL   = 2'd1,
        CLASS_INFINITE = 2'd2,
        CLASS_NAN      = 2'd3
    } operand_class_t;

    // working exponent, signed with room above 255 and below 0
    // so overflow and underflow can be seen after normalization
    typedef logic signed [9:0] exponent_t;

endpackage

`default_nettype wire
